/* logic/mipsPkg.sv */
// MIPS core shared definitions
// opcodes, function codes, ALU and forwarding encodings, memory depths
package mipsPkg;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type function field, instr[5:0]
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// ALU operation, classic three-bit control
	typedef enum logic [2:0] {
		ALU_AND = 3'b000,
		ALU_OR  = 3'b001,
		ALU_ADD = 3'b010,
		ALU_SUB = 3'b110,
		ALU_SLT = 3'b111
	} aluCtrlT;

	// execute operand source
	// reg file, writeback result or memory-stage ALU result
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwdSelT;

	// memory depths in 32-bit words
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;

	// $zero
	localparam logic [4:0] REG_ZERO = 5'd0;

endpackage

/* logic/regFile.sv */
// MIPS register file
// two async read ports, one write port on the falling clock edge
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        writeEn,
	input  logic [4:0]  readAddrA,
	input  logic [4:0]  readAddrB,
	input  logic [4:0]  writeAddr,
	input  logic [31:0] writeData,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB
);

	logic [31:0] regs [32];

	// write in first half of the cycle so decode sees it the same cycle
	always_ff @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != REG_ZERO)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// $zero always reads back as zero
	assign readDataA = (readAddrA == REG_ZERO) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == REG_ZERO) ? '0 : regs[readAddrB];

endmodule

/* logic/fetchDecode.sv */
// MIPS fetch and decode stages
// PC, instruction memory, fetch/decode register, control decode, beq/j resolution
`timescale 1ns/1ps

module fetchDecode import mipsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          progWe,
	input  logic [$clog2(IMEM_WORDS)-1:0] progAddr,
	input  logic [31:0]                   progData,
	input  logic                          stallF,
	input  logic                          stallD,
	input  logic                          forwardAD,
	input  logic                          forwardBD,
	input  logic [31:0]                   aluOutM,
	input  logic [31:0]                   regReadA,
	input  logic [31:0]                   regReadB,
	output logic [4:0]                    rsD,
	output logic [4:0]                    rtD,
	output logic [4:0]                    rdD,
	output logic [31:0]                   immD,
	output logic [31:0]                   srcAD,
	output logic [31:0]                   srcBD,
	output logic                          regWriteD,
	output logic                          memToRegD,
	output logic                          memWriteD,
	output logic                          branchD,
	output aluCtrlT                       aluCtrlD,
	output logic                          aluSrcD,
	output logic                          regDstD
);

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] pcPlus4F;
	logic [31:0] pcNext;
	logic [31:0] instrF;
	logic [31:0] instrD;
	logic [31:0] pcPlus4D;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [5:0]  opD;
	logic [5:0]  functD;
	logic        jumpD;
	logic        pcSrcD;
	logic        flushD;

	// program load port
	always_ff @(posedge clk) begin
		if (progWe) begin
			imem[progAddr] <= progData;
		end
	end

	// word-indexed async fetch read
	assign pcPlus4F = pc + 32'd4;
	assign instrF   = imem[pc[$clog2(IMEM_WORDS)+1:2]];
	// both resolve in decode and a jump wins over a branch
	assign pcNext   = jumpD ? jumpTarget : (pcSrcD ? branchTarget : pcPlus4F);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!stallF) begin
			pc <= pcNext;
		end
	end

	// fetch/decode register
	// an all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= flushD ? '0 : instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcPlus4D <= pcPlus4F;
		end
	end

	// field split
	assign opD    = instrD[31:26];
	assign functD = instrD[5:0];
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];
	assign rdD    = instrD[15:11];
	assign immD   = {{16{instrD[15]}}, instrD[15:0]};

	// operands for the early beq compare
	assign srcAD = forwardAD ? aluOutM : regReadA;
	assign srcBD = forwardBD ? aluOutM : regReadB;

	assign pcSrcD       = branchD && (srcAD == srcBD);
	// drop the instruction fetched behind a taken beq or j
	assign flushD       = pcSrcD || jumpD;
	assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// main control decode
	always_comb begin
		regWriteD = 1'b0;
		memToRegD = 1'b0;
		memWriteD = 1'b0;
		branchD   = 1'b0;
		jumpD     = 1'b0;
		aluSrcD   = 1'b0;
		regDstD   = 1'b0;
		aluCtrlD  = ALU_ADD;
		case (opD)
			OP_RTYPE: begin
				regDstD   = 1'b1;
				// unknown funct, including the zero word, writes nothing
				regWriteD = 1'b1;
				case (functD)
					FN_ADD:  aluCtrlD = ALU_ADD;
					FN_SUB:  aluCtrlD = ALU_SUB;
					FN_AND:  aluCtrlD = ALU_AND;
					FN_OR:   aluCtrlD = ALU_OR;
					FN_SLT:  aluCtrlD = ALU_SLT;
					default: regWriteD = 1'b0;
				endcase
			end
			OP_LW: begin
				regWriteD = 1'b1;
				memToRegD = 1'b1;
				aluSrcD   = 1'b1;
			end
			OP_SW: begin
				memWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			OP_ADDI: begin
				regWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			OP_BEQ: begin
				branchD  = 1'b1;
				aluCtrlD = ALU_SUB;
			end
			OP_J: begin
				jumpD = 1'b1;
			end
			default: begin
				regWriteD = 1'b0;
			end
		endcase
	end

	// a stalled fetch also holds the instruction waiting in decode
	assert property (@(posedge clk) disable iff (rst) stallF |=> $stable(instrD))
		else $error("fetch/decode register moved during a fetch stall");

endmodule

/* logic/hazardUnit.sv */
// MIPS hazard unit
// forwarding selects, load-use and branch stalls, execute flush
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  logic       branchD,
	input  logic       memToRegE,
	input  logic       regWriteE,
	input  logic       memToRegM,
	input  logic       regWriteM,
	input  logic       regWriteW,
	input  logic [4:0] rsD,
	input  logic [4:0] rtD,
	input  logic [4:0] rsE,
	input  logic [4:0] rtE,
	input  logic [4:0] writeRegE,
	input  logic [4:0] writeRegM,
	input  logic [4:0] writeRegW,
	output logic       stallF,
	output logic       stallD,
	output logic       forwardAD,
	output logic       forwardBD,
	output logic       flushE,
	output fwdSelT     forwardAE,
	output fwdSelT     forwardBE
);

	logic lwStall;
	logic branchStall;

	// memory stage is younger, so it beats writeback
	function automatic fwdSelT pickSource(
		input logic [4:0] src,
		input logic [4:0] regM,
		input logic       wrM,
		input logic [4:0] regW,
		input logic       wrW
	);
		if ((src != REG_ZERO) && (src == regM) && wrM) begin
			return FWD_MEM;
		end else if ((src != REG_ZERO) && (src == regW) && wrW) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign forwardAE = pickSource(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign forwardBE = pickSource(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	// beq compare only takes the memory-stage ALU result
	// writeback is already visible through the reg file
	assign forwardAD = (rsD != REG_ZERO) && (rsD == writeRegM) && regWriteM;
	assign forwardBD = (rtD != REG_ZERO) && (rtD == writeRegM) && regWriteM;

	// load in execute feeding the next instruction
	assign lwStall = memToRegE && ((rtE == rsD) || (rtE == rtD));

	// beq waits on an execute result or a load still in memory
	assign branchStall = branchD &&
		((regWriteE && ((writeRegE == rsD) || (writeRegE == rtD))) ||
		 (memToRegM && ((writeRegM == rsD) || (writeRegM == rtD))));

	assign stallF = lwStall || branchStall;
	assign stallD = lwStall || branchStall;
	assign flushE = lwStall || branchStall;

endmodule

/* logic/executeStage.sv */
// MIPS execute stage
// decode/execute register, operand forwarding, destination select and ALU
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        flushE,
	input  logic        regWriteD,
	input  logic        memToRegD,
	input  logic        memWriteD,
	input  aluCtrlT     aluCtrlD,
	input  logic        aluSrcD,
	input  logic        regDstD,
	input  logic [4:0]  rsD,
	input  logic [4:0]  rtD,
	input  logic [4:0]  rdD,
	input  logic [31:0] srcAD,
	input  logic [31:0] srcBD,
	input  logic [31:0] immD,
	input  fwdSelT      forwardAE,
	input  fwdSelT      forwardBE,
	input  logic [31:0] aluOutM,
	input  logic [31:0] resultW,
	output logic [4:0]  rsE,
	output logic [4:0]  rtE,
	output logic [4:0]  writeRegE,
	output logic        regWriteE,
	output logic        memToRegE,
	output logic        memWriteE,
	output logic [31:0] aluOutE,
	output logic [31:0] writeDataE
);

	aluCtrlT     aluCtrlE;
	logic        aluSrcE;
	logic        regDstE;
	logic [4:0]  rdE;
	logic [31:0] srcAE;
	logic [31:0] srcBE;
	logic [31:0] immE;
	logic [31:0] fwdAE;
	logic [31:0] aluBE;

	// controls and indices, bubble on flush
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			aluSrcE   <= 1'b0;
			regDstE   <= 1'b0;
			aluCtrlE  <= ALU_ADD;
			rsE       <= '0;
			rtE       <= '0;
			rdE       <= '0;
		end else begin
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
			memWriteE <= memWriteD;
			aluSrcE   <= aluSrcD;
			regDstE   <= regDstD;
			aluCtrlE  <= aluCtrlD;
			rsE       <= rsD;
			rtE       <= rtD;
			rdE       <= rdD;
		end
	end

	// operand values
	always_ff @(posedge clk) begin
		srcAE <= srcAD;
		srcBE <= srcBD;
		immE  <= immD;
	end

	// forwarding muxes
	always_comb begin
		case (forwardAE)
			FWD_MEM: fwdAE = aluOutM;
			FWD_WB:  fwdAE = resultW;
			default: fwdAE = srcAE;
		endcase
		case (forwardBE)
			FWD_MEM: writeDataE = aluOutM;
			FWD_WB:  writeDataE = resultW;
			default: writeDataE = srcBE;
		endcase
	end

	assign aluBE     = aluSrcE ? immE : writeDataE;
	// rd for R-type, rt for addi and lw
	assign writeRegE = regDstE ? rdE : rtE;

	always_comb begin
		case (aluCtrlE)
			ALU_AND: aluOutE = fwdAE & aluBE;
			ALU_OR:  aluOutE = fwdAE | aluBE;
			ALU_SUB: aluOutE = fwdAE - aluBE;
			// signed compare
			ALU_SLT: aluOutE = {31'd0, $signed(fwdAE) < $signed(aluBE)};
			default: aluOutE = fwdAE + aluBE;
		endcase
	end

endmodule

/* logic/memWriteback.sv */
// MIPS memory and writeback stages
// execute/memory register, data memory, memory/writeback register, result mux
`timescale 1ns/1ps

module memWriteback import mipsPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        regWriteE,
	input  logic        memToRegE,
	input  logic        memWriteE,
	input  logic [31:0] aluOutE,
	input  logic [31:0] writeDataE,
	input  logic [4:0]  writeRegE,
	output logic [31:0] aluOutM,
	output logic [4:0]  writeRegM,
	output logic        regWriteM,
	output logic        memToRegM,
	output logic        memWrite,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	output logic [31:0] resultW,
	output logic [4:0]  writeRegW,
	output logic        regWriteW
);

	logic [31:0]                   dmem [DMEM_WORDS];
	logic                          memWriteM;
	logic [31:0]                   writeDataM;
	logic [$clog2(DMEM_WORDS)-1:0] dmemIdx;
	logic [31:0]                   readDataM;
	logic                          memToRegW;
	logic [31:0]                   readDataW;
	logic [31:0]                   aluOutW;

	// execute/memory register
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM    <= aluOutE;
		writeDataM <= writeDataE;
		writeRegM  <= writeRegE;
	end

	// word-addressed data memory, byte offset ignored
	assign dmemIdx   = aluOutM[$clog2(DMEM_WORDS)+1:2];
	assign readDataM = dmem[dmemIdx];

	always_ff @(posedge clk) begin
		if (memWriteM) begin
			dmem[dmemIdx] <= writeDataM;
		end
	end

	// store seen at the top in the cycle it writes
	assign memWrite = memWriteM;
	assign memAddr  = aluOutM;
	assign memWdata = writeDataM;

	// memory/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
		end
	end

	always_ff @(posedge clk) begin
		readDataW <= readDataM;
		aluOutW   <= aluOutM;
		writeRegW <= writeRegM;
	end

	// loaded word or ALU result
	assign resultW = memToRegW ? readDataW : aluOutW;

	assert property (@(posedge clk) disable iff (rst) memWrite |-> (memAddr[1:0] == 2'b00))
		else $error("unaligned store to %h", memAddr);

endmodule

/* logic/mipsCore.sv */
// five-stage MIPS integer core
// stage blocks, register file and hazard unit wired together
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          progWe,
	input  logic [$clog2(IMEM_WORDS)-1:0] progAddr,
	input  logic [31:0]                   progData,
	output logic                          memWrite,
	output logic [31:0]                   memAddr,
	output logic [31:0]                   memWdata
);

	// decode outputs
	logic [4:0]  rsD;
	logic [4:0]  rtD;
	logic [4:0]  rdD;
	logic [31:0] immD;
	logic [31:0] srcAD;
	logic [31:0] srcBD;
	logic [31:0] regReadA;
	logic [31:0] regReadB;
	logic        regWriteD;
	logic        memToRegD;
	logic        memWriteD;
	logic        branchD;
	aluCtrlT     aluCtrlD;
	logic        aluSrcD;
	logic        regDstD;

	// hazard controls
	logic        stallF;
	logic        stallD;
	logic        forwardAD;
	logic        forwardBD;
	logic        flushE;
	fwdSelT      forwardAE;
	fwdSelT      forwardBE;

	// execute outputs
	logic [4:0]  rsE;
	logic [4:0]  rtE;
	logic [4:0]  writeRegE;
	logic        regWriteE;
	logic        memToRegE;
	logic        memWriteE;
	logic [31:0] aluOutE;
	logic [31:0] writeDataE;

	// memory and writeback results, also the forwarding sources
	logic [31:0] aluOutM;
	logic [4:0]  writeRegM;
	logic        regWriteM;
	logic        memToRegM;
	logic [31:0] resultW;
	logic [4:0]  writeRegW;
	logic        regWriteW;

	fetchDecode uFetchDecode (.*);

	// reads for decode, write from writeback
	regFile uRegFile (
		.clk       (clk),
		.rst       (rst),
		.writeEn   (regWriteW),
		.readAddrA (rsD),
		.readAddrB (rtD),
		.writeAddr (writeRegW),
		.writeData (resultW),
		.readDataA (regReadA),
		.readDataB (regReadB)
	);

	hazardUnit uHazard (.*);

	executeStage uExecute (.*);

	memWriteback uMemWriteback (.*);

endmodule

/* verification/tbMipsCore.sv */
// directed testbench for the five-stage MIPS core
// builds small programs, loads them during reset and checks every store
`timescale 1ns/1ps

module tbMipsCore import mipsPkg::*; ();

	localparam int PA_W          = $clog2(IMEM_WORDS);
	localparam int RESET_CYCLES  = 5;
	localparam int STORE_TIMEOUT = 200;
	localparam int QUIET_CYCLES  = 40;

	logic            clk;
	logic            rst;
	logic            progWe;
	logic [PA_W-1:0] progAddr;
	logic [31:0]     progData;
	logic            memWrite;
	logic [31:0]     memAddr;
	logic [31:0]     memWdata;

	logic [31:0] progWords [$];
	logic [31:0] expAddrQ [$];
	logic [31:0] expDataQ [$];
	logic [31:0] gotAddrQ [$];
	logic [31:0] gotDataQ [$];
	int          errors;
	int          checks;

	mipsCore u_dut (
		.clk      (clk),
		.rst      (rst),
		.progWe   (progWe),
		.progAddr (progAddr),
		.progData (progData),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWdata (memWdata)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// store monitor, outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && memWrite) begin
			gotAddrQ.push_back(memAddr);
			gotDataQ.push_back(memWdata);
		end
	end

	// instruction encoders
	function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jInstr(input int wordIdx);
		return {OP_J, 26'(wordIdx)};
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// program end, spins in place
	task automatic jumpToSelf();
		progWords.push_back(jInstr(progWords.size()));
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		expAddrQ.push_back(addr);
		expDataQ.push_back(data);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// load under reset, release, collect and compare the stores
	task automatic runProgram(input string name);
		int waitCycles;
		int nExp;
		int nCmp;
		nExp = expAddrQ.size();
		@(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		gotAddrQ.delete();
		gotDataQ.delete();
		foreach (progWords[i]) begin
			progWe   <= 1'b1;
			progAddr <= PA_W'(i);
			progData <= progWords[i];
			@(posedge clk);
		end
		// nop behind the final jump
		progAddr <= PA_W'(progWords.size());
		progData <= '0;
		@(posedge clk);
		progWe <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		waitCycles = 0;
		while ((gotAddrQ.size() < nExp) && (waitCycles < STORE_TIMEOUT)) begin
			@(posedge clk);
			waitCycles++;
		end
		if (gotAddrQ.size() < nExp) begin
			$display("%s: store %0d of %0d never came", name, gotAddrQ.size() + 1, nExp);
			errors++;
		end
		// skipped stores would show up in this window
		repeat (QUIET_CYCLES) @(posedge clk);
		if (gotAddrQ.size() > nExp) begin
			$display("%s: %0d stores seen where only %0d belong to the program",
				name, gotAddrQ.size(), nExp);
			errors++;
		end
		nCmp = (gotAddrQ.size() < nExp) ? gotAddrQ.size() : nExp;
		for (int i = 0; i < nCmp; i++) begin
			checkValue($sformatf("%s memAddr[%0d]", name, i), gotAddrQ[i], expAddrQ[i]);
			checkValue($sformatf("%s memWdata[%0d]", name, i), gotDataQ[i], expDataQ[i]);
		end
		progWords.delete();
		expAddrQ.delete();
		expDataQ.delete();
	endtask

	// dependent ALU chain, each result from M or W forwarding
	task automatic aluForwarding();
		logic [31:0] sa;
		logic [31:0] sb;
		logic [31:0] s3;
		logic [31:0] s4;
		logic [31:0] s5;
		logic [31:0] s6;
		sa = sext16(16'd100);
		sb = sext16(16'hffdb);
		s3 = sa + sb;
		s4 = s3 - sa;
		s5 = s4 & s3;
		s6 = s5 | sb;
		progWords.push_back(iInstr(OP_ADDI, 5'd1, 5'd0, 16'd100));
		progWords.push_back(iInstr(OP_ADDI, 5'd2, 5'd0, 16'hffdb));
		progWords.push_back(rInstr(FN_ADD, 5'd3, 5'd1, 5'd2));
		progWords.push_back(rInstr(FN_SUB, 5'd4, 5'd3, 5'd1));
		progWords.push_back(rInstr(FN_AND, 5'd5, 5'd4, 5'd3));
		progWords.push_back(rInstr(FN_OR, 5'd6, 5'd5, 5'd2));
		progWords.push_back(rInstr(FN_SLT, 5'd7, 5'd2, 5'd3));
		// store data forwarded straight from the slt
		progWords.push_back(iInstr(OP_SW, 5'd7, 5'd0, 16'h0050));
		progWords.push_back(iInstr(OP_SW, 5'd3, 5'd0, 16'h0040));
		progWords.push_back(iInstr(OP_SW, 5'd4, 5'd0, 16'h0044));
		progWords.push_back(iInstr(OP_SW, 5'd5, 5'd0, 16'h0048));
		progWords.push_back(iInstr(OP_SW, 5'd6, 5'd0, 16'h004c));
		jumpToSelf();
		expectStore(32'h50, ($signed(sb) < $signed(s3)) ? 32'd1 : 32'd0);
		expectStore(32'h40, s3);
		expectStore(32'h44, s4);
		expectStore(32'h48, s5);
		expectStore(32'h4c, s6);
		runProgram("forwarding");
	endtask

	// lw followed at once by its consumer
	task automatic loadUseStall();
		progWords.push_back(iInstr(OP_ADDI, 5'd1, 5'd0, 16'd25));
		progWords.push_back(iInstr(OP_ADDI, 5'd2, 5'd0, 16'd17));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h0080));
		progWords.push_back(iInstr(OP_LW, 5'd3, 5'd0, 16'h0080));
		progWords.push_back(rInstr(FN_ADD, 5'd4, 5'd3, 5'd2));
		progWords.push_back(iInstr(OP_SW, 5'd4, 5'd0, 16'h0084));
		jumpToSelf();
		expectStore(32'h80, 32'd25);
		expectStore(32'h84, 32'd25 + 32'd17);
		runProgram("load-use");
	endtask

	// taken and not-taken beq, some right behind their producer
	task automatic branchPaths();
		progWords.push_back(iInstr(OP_ADDI, 5'd1, 5'd0, 16'd5));
		progWords.push_back(iInstr(OP_ADDI, 5'd2, 5'd0, 16'd5));
		progWords.push_back(iInstr(OP_BEQ, 5'd2, 5'd1, 16'd1));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h00a0));
		progWords.push_back(iInstr(OP_ADDI, 5'd3, 5'd0, 16'd9));
		// not taken, 9 against 5
		progWords.push_back(iInstr(OP_BEQ, 5'd1, 5'd3, 16'd1));
		progWords.push_back(iInstr(OP_SW, 5'd3, 5'd0, 16'h00a4));
		// load feeding the compare, stalls twice
		progWords.push_back(iInstr(OP_LW, 5'd4, 5'd0, 16'h00a4));
		progWords.push_back(iInstr(OP_BEQ, 5'd3, 5'd4, 16'd1));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h00b0));
		progWords.push_back(iInstr(OP_BEQ, 5'd0, 5'd0, 16'd1));
		progWords.push_back(iInstr(OP_SW, 5'd3, 5'd0, 16'h00a8));
		progWords.push_back(iInstr(OP_SW, 5'd2, 5'd0, 16'h00ac));
		jumpToSelf();
		expectStore(32'ha4, 32'd9);
		expectStore(32'hac, 32'd5);
		runProgram("branches");
	endtask

	task automatic jumpOverStore();
		int target;
		progWords.push_back(iInstr(OP_ADDI, 5'd1, 5'd0, 16'h0033));
		// j lands three words further on
		target = progWords.size() + 3;
		progWords.push_back(jInstr(target));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h00c0));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h00c4));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h00c8));
		jumpToSelf();
		expectStore(32'hc8, 32'h33);
		runProgram("jump");
	endtask

	// writes to $zero vanish, no forwarding for it either
	task automatic zeroRegister();
		progWords.push_back(iInstr(OP_ADDI, 5'd0, 5'd0, 16'h0055));
		progWords.push_back(iInstr(OP_SW, 5'd0, 5'd0, 16'h00d0));
		progWords.push_back(iInstr(OP_ADDI, 5'd0, 5'd0, 16'h0066));
		progWords.push_back(rInstr(FN_ADD, 5'd1, 5'd0, 5'd0));
		progWords.push_back(iInstr(OP_SW, 5'd0, 5'd0, 16'h00d8));
		progWords.push_back(iInstr(OP_SW, 5'd1, 5'd0, 16'h00d4));
		jumpToSelf();
		expectStore(32'hd0, 32'd0);
		expectStore(32'hd8, 32'd0);
		expectStore(32'hd4, 32'd0);
		runProgram("zero-register");
	endtask

	task automatic randomOperands();
		logic [31:0] rnd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] base;
		for (int k = 0; k < 4; k++) begin
			rnd = $urandom();
			a = rnd[15:0];
			rnd = $urandom();
			b = rnd[15:0];
			base = 16'h0100 + 16'(k * 8);
			progWords.push_back(iInstr(OP_ADDI, 5'd1, 5'd0, a));
			progWords.push_back(iInstr(OP_ADDI, 5'd2, 5'd0, b));
			progWords.push_back(rInstr(FN_ADD, 5'd3, 5'd1, 5'd2));
			progWords.push_back(rInstr(FN_SUB, 5'd4, 5'd1, 5'd2));
			progWords.push_back(iInstr(OP_SW, 5'd3, 5'd0, base));
			progWords.push_back(iInstr(OP_SW, 5'd4, 5'd0, base + 16'd4));
			expectStore({16'd0, base}, sext16(a) + sext16(b));
			expectStore({16'd0, base + 16'd4}, sext16(a) - sext16(b));
		end
		jumpToSelf();
		runProgram("random");
	endtask

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		progWe   = 1'b0;
		progAddr = '0;
		progData = '0;
		errors   = 0;
		checks   = 0;
		void'($urandom(32'h1ed5));
		aluForwarding();
		loadUseStall();
		branchPaths();
		jumpOverStore();
		zeroRegister();
		randomOperands();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
logic/mipsPkg.sv
logic/regFile.sv
logic/fetchDecode.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/mipsCore.sv
verification/tbMipsCore.sv
